// ==== flist.f ====
+incdir+testbench
rtl/coms_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/frame_parser.sv
rtl/reply_builder.sv
rtl/coms_top.sv
testbench/tb_coms.sv

// ==== run.sh ====
#!/bin/sh
# build and run tb_coms with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary -Wno-fatal --top-module tb_coms -f flist.f -o tb_coms > build.log 2>&1 \
	&& ./obj_dir/tb_coms > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qxF "** PASS **" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== testbench/tb_tasks.svh ====
//////////////////////////////////////////////////////////////////////
// serial line

// 8N1, one bit per CLKS_PER_BIT clocks, changes on the falling edge
task automatic send_byte(input byte_t b);
	logic [9:0] frame_bits;
	frame_bits = {1'b1, b, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(negedge CLK);
		rx = frame_bits[i];
		repeat (CLKS_PER_BIT - 1) @(negedge CLK);
	end
endtask

task automatic send_frame();
	while (send_q.size() > 0) begin
		send_byte(send_q.pop_front());
	end
endtask

// find the start bit, then sample every bit in its middle
task automatic receive_byte(output byte_t b, output logic ok);
	int waited;
	ok = 1'b0;
	b = '0;
	waited = 0;
	@(negedge CLK);
	while (tx !== 1'b0 && waited < START_TIMEOUT) begin
		@(negedge CLK);
		waited++;
	end
	if (tx !== 1'b0) begin
		$display("%0t: timeout, no start bit on tx within %0d clocks", $time, START_TIMEOUT);
		timeout_count++;
	end else begin
		repeat (CLKS_PER_BIT / 2) @(negedge CLK);
		check_bit("tx", 1'b0, tx);
		check_bit("tx_enable", 1'b1, tx_enable);
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge CLK);
			b[i] = tx;
			check_bit("tx_enable", 1'b1, tx_enable);
		end
		repeat (CLKS_PER_BIT) @(negedge CLK);
		// stop bit
		check_bit("tx", 1'b1, tx);
		check_bit("tx_enable", 1'b1, tx_enable);
		ok = 1'b1;
	end
endtask

//////////////////////////////////////////////////////////////////////
// compares

task automatic check_bit(input string name, input logic expected, input logic actual);
	check_count++;
	if (actual !== expected) begin
		mismatch_count++;
		$display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
	end
endtask

task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
	check_count++;
	if (actual !== expected) begin
		mismatch_count++;
		$display("Mismatch at %0t: %s expected 0x%02h, got 0x%02h",
			$time, name, expected, actual);
	end
endtask

task automatic check_word(input string name, input word_t expected, input word_t actual);
	check_count++;
	if (actual !== expected) begin
		mismatch_count++;
		$display("Mismatch at %0t: %s expected %0d (0x%08h), got %0d (0x%08h)",
			$time, name, expected, expected, actual, actual);
	end
endtask

//////////////////////////////////////////////////////////////////////
// frame builders

task automatic push_magic(input logic [31:0] magic);
	for (int i = 3; i >= 0; i--) begin
		send_q.push_back(magic[8*i +: 8]);
	end
endtask

// printable junk never matches a magic byte, the last three start a status magic
task automatic add_junk(input int count);
	for (int n = 0; n < count; n++) begin
		send_q.push_back(8'h20 + 8'($urandom % 96));
	end
	for (int i = 3; i >= 1; i--) begin
		send_q.push_back(STATUS_REQ_MAGIC[8*i +: 8]);
	end
endtask

task automatic add_status_req(input byte_t node);
	byte_t data[$];
	crc_t c;
	data.push_back(node);
	c = crc_ref(data);
	push_magic(STATUS_REQ_MAGIC);
	send_q.push_back(node);
	send_q.push_back(c[15:8]);
	send_q.push_back(c[7:0]);
endtask

task automatic add_setpoint_frame(input byte_t node, input word_t value, input logic bad_crc,
		output crc_t good_crc);
	byte_t data[$];
	data.push_back(node);
	for (int i = 3; i >= 0; i--) begin
		data.push_back(value[8*i +: 8]);
	end
	good_crc = crc_ref(data);
	push_magic(SETPOINT_MAGIC);
	foreach (data[n]) begin
		send_q.push_back(data[n]);
	end
	// a corrupted high byte still gets the computed high byte back as nack
	send_q.push_back(bad_crc ? ~good_crc[15:8] : good_crc[15:8]);
	send_q.push_back(good_crc[7:0]);
endtask

// ==== testbench/tb_coms.sv ====
`timescale 1ns/10ps

module tb_coms import coms_pkg::*; ();

	// x^16 + x^15 + x^2 + 1
	localparam crc_t REF_POLY = 16'h8005;
	localparam int START_TIMEOUT = 5000;
	localparam int REPLY_TIMEOUT = 8000;
	localparam int IDLE_TIMEOUT = 2 * CLKS_PER_BIT;
	localparam int QUIET_CYCLES = 2 * CLKS_PER_BIT;

	logic CLK;
	logic reset;
	logic rx;
	byte_t id;
	telemetry_t telemetry;
	logic tx;
	logic tx_enable;
	word_t setpoint;

	// bytes still to go out on rx, and reply bytes still owed on tx
	byte_t send_q[$];
	byte_t exp_q[$];
	word_t sp_model;
	int check_count = 0;
	int mismatch_count = 0;
	int timeout_count = 0;

	coms_top dut0 (
		.CLK(CLK),
		.reset(reset),
		.rx(rx),
		.id(id),
		.telemetry(telemetry),
		.tx(tx),
		.tx_enable(tx_enable),
		.setpoint(setpoint)
	);

	always #50 CLK = ~CLK;

	//////////////////////////////////////////////////////////////////////
	// reference model

	// bitwise crc over a byte list, msb first
	function automatic crc_t crc_ref(input byte_t data[$]);
		crc_t c;
		logic top;
		c = 16'hFFFF;
		foreach (data[n]) begin
			for (int k = 7; k >= 0; k--) begin
				top = c[15];
				c = c << 1;
				if (top != data[n][k]) begin
					c = c ^ REF_POLY;
				end
			end
		end
		return c;
	endfunction

	`include "tb_tasks.svh"

	// magic, id, position, velocity, displacement, current, crc
	task automatic expect_status_frame(input byte_t node, input telemetry_t tel);
		byte_t body[$];
		crc_t c;
		body.push_back(node);
		for (int i = 3; i >= 0; i--) begin
			body.push_back(tel.position[8*i +: 8]);
		end
		for (int i = 3; i >= 0; i--) begin
			body.push_back(tel.velocity[8*i +: 8]);
		end
		for (int i = 3; i >= 0; i--) begin
			body.push_back(tel.displacement[8*i +: 8]);
		end
		body.push_back(tel.current[15:8]);
		body.push_back(tel.current[7:0]);
		c = crc_ref(body);
		for (int i = 3; i >= 0; i--) begin
			exp_q.push_back(STATUS_MAGIC[8*i +: 8]);
		end
		foreach (body[n]) begin
			exp_q.push_back(body[n]);
		end
		exp_q.push_back(c[15:8]);
		exp_q.push_back(c[7:0]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequences

	task automatic randomize_inputs();
		id = byte_t'($urandom);
		telemetry.position = word_t'($urandom);
		telemetry.velocity = word_t'($urandom);
		telemetry.displacement = word_t'($urandom);
		telemetry.current = current_t'($urandom);
	endtask

	task automatic idle_check(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			@(negedge CLK);
			check_bit("tx", 1'b1, tx);
			check_bit("tx_enable", 1'b0, tx_enable);
			check_word("setpoint", '0, setpoint);
		end
	endtask

	// send what is queued, then wait for the whole reply and the line to go quiet
	task automatic exchange();
		int waited;
		waited = 0;
		send_frame();
		while (exp_q.size() > 0 && waited < REPLY_TIMEOUT) begin
			@(negedge CLK);
			waited++;
		end
		if (exp_q.size() > 0) begin
			$display("%0t: timeout, reply still missing %0d bytes", $time, exp_q.size());
			timeout_count++;
			exp_q.delete();
		end
		waited = 0;
		while (tx_enable !== 1'b0 && waited < IDLE_TIMEOUT) begin
			@(negedge CLK);
			waited++;
		end
		if (tx_enable !== 1'b0) begin
			$display("%0t: timeout, tx_enable stayed high after the reply", $time);
			timeout_count++;
		end
		// nothing more goes out after the last reply byte
		for (int n = 0; n < QUIET_CYCLES; n++) begin
			@(negedge CLK);
			check_bit("tx", 1'b1, tx);
			check_bit("tx_enable", 1'b0, tx_enable);
		end
	endtask

	task automatic run_setpoint(input logic bad_crc, input logic with_junk);
		word_t value;
		crc_t c;
		value = word_t'($urandom);
		if (with_junk) begin
			add_junk(4 + int'($urandom % 5));
		end
		add_setpoint_frame(id, value, bad_crc, c);
		if (bad_crc) begin
			exp_q.push_back(c[15:8]);
		end else begin
			exp_q.push_back(ACK_BYTE);
			sp_model = value;
		end
		exchange();
		check_word("setpoint", sp_model, setpoint);
	endtask

	task automatic run_status(input logic with_junk);
		if (with_junk) begin
			add_junk(4 + int'($urandom % 5));
		end
		add_status_req(id);
		expect_status_frame(id, telemetry);
		exchange();
	endtask

	// pulls reply bytes off tx while any are expected
	initial begin : reply_checker
		byte_t got;
		logic ok;
		forever begin
			@(negedge CLK);
			if (exp_q.size() > 0) begin
				receive_byte(got, ok);
				if (ok && exp_q.size() > 0) begin
					check_byte("tx", exp_q[0], got);
					exp_q.delete(0);
				end else begin
					exp_q.delete();
				end
			end
		end
	end

	initial begin : stimulus
		int unsigned seed;
		int pick;
		CLK = 1'b0;
		reset = 1'b1;
		rx = 1'b1;
		id = '0;
		telemetry = '0;
		sp_model = '0;
		seed = $urandom(52);
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;

		idle_check(100);
		randomize_inputs();
		run_setpoint(1'b0, 1'b0);
		run_setpoint(1'b1, 1'b0);
		randomize_inputs();
		run_status(1'b0);
		randomize_inputs();
		run_status(1'b1);
		run_setpoint(1'b0, 1'b1);

		// frames one after another, each once the last reply is in
		for (int r = 0; r < 6; r++) begin
			randomize_inputs();
			pick = int'($urandom % 3);
			case (pick)
				0: run_status(1'b0);
				1: run_setpoint(1'b0, 1'b0);
				default: run_setpoint(1'b1, 1'b0);
			endcase
		end

		$display("checks %0d, mismatches %0d, timeouts %0d",
			check_count, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== rtl/coms_top.sv ====
`timescale 1ns/10ps

module coms_top import coms_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic rx,
	input byte_t id,
	input telemetry_t telemetry,
	output logic tx,
	output logic tx_enable,
	output word_t setpoint
);

	byte_t rx_data;
	logic rx_valid;
	frame_event_t evt;
	logic evt_valid;
	byte_t tx_data;
	logic tx_start;
	logic tx_busy;
	logic tx_done;

	//////////////////////////////////////////////////////////////////////
	// receive path

	uart_rx rx0 (
		.CLK(CLK),
		.reset(reset),
		.rx(rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	frame_parser parser0 (
		.CLK(CLK),
		.reset(reset),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.evt(evt),
		.evt_valid(evt_valid),
		.setpoint(setpoint)
	);

	//////////////////////////////////////////////////////////////////////
	// reply path

	reply_builder builder0 (
		.CLK(CLK),
		.reset(reset),
		.id(id),
		.telemetry(telemetry),
		.evt(evt),
		.evt_valid(evt_valid),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.tx_data(tx_data),
		.tx_start(tx_start)
	);

	uart_tx tx0 (
		.CLK(CLK),
		.reset(reset),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx(tx),
		.tx_enable(tx_enable),
		.tx_busy(tx_busy),
		.tx_done(tx_done)
	);

endmodule

// ==== rtl/reply_builder.sv ====
`timescale 1ns/10ps

module reply_builder import coms_pkg::*; (
	input logic CLK,
	input logic reset,
	input byte_t id,
	input telemetry_t telemetry,
	input frame_event_t evt,
	input logic evt_valid,
	input logic tx_busy,
	input logic tx_done,
	output byte_t tx_data,
	output logic tx_start
);

	typedef enum logic [1:0] {B_IDLE, B_SEND, B_WAIT} builder_state_e;

	builder_state_e state;
	logic [4:0] byte_idx;
	// one byte reply, ack or nack
	logic single;
	byte_t single_byte;
	byte_t id_snap;
	telemetry_t tel_snap;
	crc_t crc;
	byte_t frame_byte;
	logic [8*(STATUS_LEN-MAGIC_LEN-2)-1:0] body;
	logic accept;
	logic good_status;
	logic in_body;
	logic frame_last;

	// events that come in while a reply is going out are lost
	assign accept = (state == B_IDLE) && evt_valid && !tx_busy;
	assign good_status = evt.crc_ok && (evt.kind == FRAME_STATUS_REQ);

	// id, position, velocity, displacement, current, all big endian
	assign body = {id_snap, tel_snap};
	assign in_body = (byte_idx >= 5'(MAGIC_LEN)) && (byte_idx < 5'(STATUS_LEN - 2));
	assign frame_last = single || (byte_idx == 5'(STATUS_LEN - 1));

	//////////////////////////////////////////////////////////////////////
	// status frame byte select

	always_comb begin
		int pos;
		pos = int'(byte_idx);
		if (pos < MAGIC_LEN) begin
			frame_byte = STATUS_MAGIC[31 - 8*pos -: 8];
		end else if (in_body) begin
			frame_byte = body[$bits(body) - 1 - 8*(pos - MAGIC_LEN) -: 8];
		end else if (pos == STATUS_LEN - 2) begin
			frame_byte = crc[15:8];
		end else begin
			frame_byte = crc[7:0];
		end
	end

	assign tx_data = single ? single_byte : frame_byte;

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= B_IDLE;
			byte_idx <= '0;
			single <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				B_IDLE: begin
					if (accept) begin
						byte_idx <= '0;
						single <= !good_status;
						tx_start <= 1'b1;
						state <= B_WAIT;
					end
				end
				B_SEND: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state <= B_WAIT;
					end
				end
				B_WAIT: begin
					if (tx_done) begin
						if (frame_last) begin
							state <= B_IDLE;
						end else begin
							byte_idx <= byte_idx + 5'd1;
							state <= B_SEND;
						end
					end
				end
				default: state <= B_IDLE;
			endcase
		end
	end

	// snapshot and running crc over bytes 4 to 18 as they finish
	always_ff @(posedge CLK) begin
		if (accept) begin
			id_snap <= id;
			tel_snap <= telemetry;
			crc <= CRC_INIT;
			single_byte <= evt.crc_ok ? ACK_BYTE : evt.crc_hi;
		end else if (state == B_WAIT && tx_done && !single && in_body) begin
			crc <= crc16_step(crc, frame_byte);
		end
	end

endmodule

// ==== rtl/frame_parser.sv ====
`timescale 1ns/10ps

module frame_parser import coms_pkg::*; (
	input logic CLK,
	input logic reset,
	input byte_t rx_data,
	input logic rx_valid,
	output frame_event_t evt,
	output logic evt_valid,
	output word_t setpoint
);

	typedef enum logic {P_HUNT, P_COLLECT} parser_state_e;

	parser_state_e state;
	logic [23:0] window;
	logic [31:0] window_next;
	logic [3:0] byte_cnt;
	// bytes under the crc: id plus payload
	logic [3:0] data_len;
	frame_kind_e kind;
	crc_t crc;
	byte_t crc_rx_hi;
	word_t sp_buf;
	logic last_byte;
	logic crc_match;
	logic hit_status_req;
	logic hit_setpoint;

	assign window_next = {window, rx_data};
	assign hit_status_req = (window_next == STATUS_REQ_MAGIC);
	assign hit_setpoint = (window_next == SETPOINT_MAGIC);

	assign data_len = (kind == FRAME_SETPOINT) ? 4'(SETPOINT_LEN - MAGIC_LEN - 2)
		: 4'(STATUS_REQ_LEN - MAGIC_LEN - 2);
	assign last_byte = (byte_cnt == data_len + 4'd1);
	assign crc_match = ({crc_rx_hi, rx_data} == crc);

	//////////////////////////////////////////////////////////////////////
	// frame state

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= P_HUNT;
			window <= '0;
			byte_cnt <= '0;
			evt_valid <= 1'b0;
			setpoint <= '0;
		end else begin
			evt_valid <= 1'b0;
			if (rx_valid) begin
				case (state)
					P_HUNT: begin
						window <= window_next[23:0];
						byte_cnt <= '0;
						if (hit_status_req || hit_setpoint) begin
							state <= P_COLLECT;
						end
					end
					P_COLLECT: begin
						byte_cnt <= byte_cnt + 4'd1;
						if (last_byte) begin
							evt_valid <= 1'b1;
							window <= '0;
							state <= P_HUNT;
							if (kind == FRAME_SETPOINT && crc_match) begin
								setpoint <= sp_buf;
							end
						end
					end
					default: state <= P_HUNT;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// crc and payload

	always_ff @(posedge CLK) begin
		if (rx_valid) begin
			if (state == P_HUNT) begin
				crc <= CRC_INIT;
				kind <= hit_setpoint ? FRAME_SETPOINT : FRAME_STATUS_REQ;
			end else if (byte_cnt < data_len) begin
				crc <= crc16_step(crc, rx_data);
				// the last four data bytes of a setpoint frame are the value
				sp_buf <= {sp_buf[23:0], rx_data};
			end else if (byte_cnt == data_len) begin
				crc_rx_hi <= rx_data;
			end else begin
				evt.kind <= kind;
				evt.crc_ok <= crc_match;
				evt.crc_hi <= crc[15:8];
			end
		end
	end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import coms_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic tx_start,
	input byte_t tx_data,
	output logic tx,
	output logic tx_enable,
	output logic tx_busy,
	output logic tx_done
);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	tx_state_e state;
	baud_cnt_t baud_cnt;
	logic [2:0] bit_idx;
	byte_t tx_shift;
	logic bit_end;

	assign bit_end = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					baud_cnt <= '0;
					if (tx_start) begin
						tx <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						bit_idx <= '0;
						tx <= tx_shift[0];
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							tx <= 1'b1;
							state <= TX_STOP;
						end else begin
							tx <= tx_shift[0];
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						tx_done <= 1'b1;
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// bit 0 always holds the next bit to put on the line
	always_ff @(posedge CLK) begin
		if (state == TX_IDLE && tx_start) begin
			tx_shift <= tx_data;
		end else if ((state == TX_START || state == TX_DATA) && bit_end) begin
			tx_shift <= tx_shift >> 1;
		end
	end

	// half duplex transceiver is driven for the whole byte, start to stop
	assign tx_busy = (state != TX_IDLE);
	assign tx_enable = (state != TX_IDLE);

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx import coms_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic rx,
	output byte_t rx_data,
	output logic rx_valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e state;
	logic rx_meta;
	logic rx_sync;
	baud_cnt_t baud_cnt;
	logic [2:0] bit_idx;
	byte_t rx_shift;
	logic bit_end;

	// line idles high, so the synchronizer comes out of reset high
	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	assign bit_end = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// half a bit in, still low means a real start bit
					if (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_end) begin
						// framing error drops the byte silently
						rx_valid <= rx_sync;
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge CLK) begin
		if (state == RX_DATA && bit_end) begin
			rx_shift <= {rx_sync, rx_shift[7:1]};
		end
	end

	assign rx_data = rx_shift;

endmodule

// ==== rtl/coms_pkg.sv ====
package coms_pkg;

	////////////////////////////////////////////////////////////////////
	// basic widths

	typedef logic [7:0] byte_t;
	typedef logic signed [31:0] word_t;
	typedef logic [15:0] current_t;
	typedef logic [15:0] crc_t;

	// uart bit timing
	localparam int CLKS_PER_BIT = 16;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

	// motor measurements, sent in this order in the status frame
	typedef struct packed {
		word_t position;
		word_t velocity;
		word_t displacement;
		current_t current;
	} telemetry_t;

	typedef enum logic {
		FRAME_STATUS_REQ,
		FRAME_SETPOINT
	} frame_kind_e;

	// one parsed frame, handed from the parser to the reply side
	typedef struct packed {
		frame_kind_e kind;
		logic crc_ok;
		byte_t crc_hi;
	} frame_event_t;

	////////////////////////////////////////////////////////////////////
	// frame layout

	localparam int MAGIC_LEN = 4;
	localparam logic [31:0] STATUS_REQ_MAGIC = 32'h1CE1CEBB;
	localparam int STATUS_REQ_LEN = 7;
	localparam logic [31:0] SETPOINT_MAGIC = 32'hD0D0D0D0;
	localparam int SETPOINT_LEN = 11;
	localparam logic [31:0] STATUS_MAGIC = 32'h1CEB00DA;
	localparam int STATUS_LEN = 21;

	localparam crc_t CRC_INIT = 16'hFFFF;
	// x^16 + x^15 + x^2 + 1
	localparam crc_t CRC_POLY = 16'h8005;
	localparam byte_t ACK_BYTE = 8'h00;

	// one byte through the crc, msb first, no reflection
	function automatic crc_t crc16_step(crc_t crc, byte_t data);
		crc_t c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (fb) begin
				c = c ^ CRC_POLY;
			end
		end
		return c;
	endfunction

endpackage
